/* sound_pkg.sv */
/* shared widths and mixer register map of the SB16 style mixer slice
   index constants follow the SB Pro / SB16 mixer layout */
`default_nettype none

package sound_pkg;

	// offset inside the 16-byte host I/O window
	typedef logic [3:0] io_addr_t;

	// host data byte
	typedef logic [7:0] host_data_t;

	// mixer register index, written at IO_MIX_INDEX
	typedef logic [7:0] mix_idx_t;

	// volume level, 0 is muted and 31 is full scale
	typedef logic [4:0] vol_t;

	// signed PCM sample
	typedef logic signed [15:0] sample_t;

	// host window offsets
	localparam io_addr_t IO_MIX_INDEX = 4'h4;
	localparam io_addr_t IO_MIX_DATA  = 4'h5;

	// writing any data here resets the mixer levels
	localparam mix_idx_t MIX_RESET = 8'h00;

	// SB Pro packed pairs, left in the high nibble
	localparam mix_idx_t MIX_VOICE_PAIR  = 8'h04;
	localparam mix_idx_t MIX_STEREO      = 8'h0E;
	localparam mix_idx_t MIX_MASTER_PAIR = 8'h22;
	localparam mix_idx_t MIX_FM_PAIR     = 8'h26;
	localparam mix_idx_t MIX_CD_PAIR     = 8'h28;
	localparam mix_idx_t MIX_LINE_PAIR   = 8'h2E;

	// SB16 single registers, 5-bit levels in bits 7..3
	localparam mix_idx_t MIX_SB16_LO = 8'h30;
	localparam mix_idx_t MIX_SB16_HI = 8'h3E;

	// card configuration and interrupt status
	localparam mix_idx_t MIX_IRQ_CFG  = 8'h80;
	localparam mix_idx_t MIX_DMA_CFG  = 8'h81;
	localparam mix_idx_t MIX_IRQ_STAT = 8'h82;

endpackage

`default_nettype wire

/* sound_host_port.sv */
/* host window decode; only offsets 4 and 5 belong to the mixer, the index port
   is write-only, and every other read returns the open-bus value 0xFF */
`timescale 1ns/100ps
`default_nettype none

module sound_host_port (
	input  wire                  clk,
	input  wire                  rst_n,
	input  sound_pkg::io_addr_t  address,
	input  wire                  read,
	input  wire                  write,
	input  wire                  sb_cs,
	input  sound_pkg::host_data_t writedata,
	input  sound_pkg::host_data_t mix_rdata,
	input  wire                  irq8,
	input  wire                  irq16,
	input  wire                  irq_sel_7,
	input  wire                  irq_sel_10,
	output logic                 idx_wr,
	output logic                 data_wr,
	output logic                 data_rd,
	output sound_pkg::host_data_t wr_data,
	output sound_pkg::host_data_t readdata,
	output logic                 rd_valid,
	output logic                 irq_5,
	output logic                 irq_7,
	output logic                 irq_10
);

	import sound_pkg::*;

	localparam host_data_t OPEN_BUS = 8'hFF;

	logic host_rd; // any qualified read
	logic host_wr;
	logic irq_any;

	assign host_rd = read & sb_cs;
	assign host_wr = write & sb_cs;

	// strobes toward the mixer
	assign idx_wr  = host_wr && (address == IO_MIX_INDEX);
	assign data_wr = host_wr && (address == IO_MIX_DATA);
	assign data_rd = host_rd && (address == IO_MIX_DATA);
	assign wr_data = writedata;

	// readback lands one cycle after the strobe
	always_ff @(posedge clk) begin
		if (host_rd)
			readdata <= data_rd ? mix_rdata : OPEN_BUS;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= host_rd;
	end

	// both DSP requests share the one selected line
	assign irq_any = irq8 | irq16;

	assign irq_7  = irq_any & irq_sel_7;
	assign irq_10 = irq_any & irq_sel_10;
	assign irq_5  = irq_any & ~irq_sel_7 & ~irq_sel_10; // default line

endmodule

`default_nettype wire

/* sound_mixer_regs.sv */
/* mixer register bank; a data write at index 0 acts like rst_n and restores every
   level, mask and card setting, and the 0x3x block is hidden in SB Pro mode */
`timescale 1ns/100ps
`default_nettype none

module sound_mixer_regs (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   idx_wr,
	input  wire                   data_wr,
	input  wire                   data_rd,
	input  sound_pkg::host_data_t wr_data,
	input  wire                   irq8,
	input  wire                   irq16,
	output sound_pkg::host_data_t mix_rdata,
	output logic                  irq_sel_7,
	output logic                  irq_sel_10,
	output logic                  sb_pro,
	output sound_pkg::vol_t       vol_voice_l,
	output sound_pkg::vol_t       vol_voice_r,
	output sound_pkg::vol_t       vol_fm_l,
	output sound_pkg::vol_t       vol_fm_r,
	output sound_pkg::vol_t       vol_master_l,
	output sound_pkg::vol_t       vol_master_r,
	output logic [1:0]            vol_spk
);

	import sound_pkg::*;

	localparam vol_t       VOL_FULL  = 5'd31;
	localparam host_data_t SBPRO_ON  = 8'hAD;
	localparam host_data_t SBPRO_OFF = 8'hAE;

	mix_idx_t   idx;
	vol_t       vol_cd_l;
	vol_t       vol_cd_r;
	vol_t       vol_line_l;
	vol_t       vol_line_r;
	logic [4:0] out_en;   // output switches
	logic [6:0] rec_en_l; // record source masks
	logic [6:0] rec_en_r;
	logic       sbp_stereo;
	logic       dma16_en;
	logic       irq_sel_5;
	logic       mix_reset;
	logic       sb16_hit;
	vol_t       pair_l;
	vol_t       pair_r;
	host_data_t pro_mask;
	host_data_t sb16_val;
	host_data_t rdata;

	always_ff @(posedge clk) begin
		if (!rst_n)
			idx <= MIX_RESET;
		else if (idx_wr)
			idx <= wr_data;
	end

	assign mix_reset = data_wr && (idx == MIX_RESET);
	assign sb16_hit  = (idx >= MIX_SB16_LO) && (idx <= MIX_SB16_HI);

	// nibble widened to 5 bits; SB Pro drops the low bit of each nibble
	assign pair_l = sb_pro ? {wr_data[7:5], wr_data[7:6]} : {wr_data[7:4], wr_data[7]};
	assign pair_r = sb_pro ? {wr_data[3:1], wr_data[3:2]} : {wr_data[3:0], wr_data[3]};

	always_ff @(posedge clk) begin
		if (!rst_n || mix_reset) begin
			vol_master_l <= VOL_FULL;
			vol_master_r <= VOL_FULL;
			vol_voice_l  <= VOL_FULL;
			vol_voice_r  <= VOL_FULL;
			vol_fm_l     <= VOL_FULL;
			vol_fm_r     <= VOL_FULL;
			vol_cd_l     <= VOL_FULL;
			vol_cd_r     <= VOL_FULL;
			vol_line_l   <= VOL_FULL;
			vol_line_r   <= VOL_FULL;
			vol_spk      <= 2'd3;
			out_en       <= 5'h1F;
			rec_en_l     <= 7'h15;
			rec_en_r     <= 7'h0B;
			sbp_stereo   <= 1'b0;
		end else if (data_wr) begin
			case (idx)
				MIX_VOICE_PAIR: begin
					vol_voice_l <= pair_l;
					vol_voice_r <= pair_r;
				end
				MIX_STEREO: sbp_stereo <= wr_data[1] & sb_pro; // SB Pro only
				MIX_MASTER_PAIR: begin
					vol_master_l <= pair_l;
					vol_master_r <= pair_r;
				end
				MIX_FM_PAIR: begin
					vol_fm_l <= pair_l;
					vol_fm_r <= pair_r;
				end
				MIX_CD_PAIR: begin
					vol_cd_l <= pair_l;
					vol_cd_r <= pair_r;
				end
				MIX_LINE_PAIR: begin
					vol_line_l <= pair_l;
					vol_line_r <= pair_r;
				end
				default: ;
			endcase

			// SB16 block is invisible in SB Pro mode
			if (sb16_hit && !sb_pro) begin
				case (idx[3:0])
					4'h0: vol_master_l <= wr_data[7:3];
					4'h1: vol_master_r <= wr_data[7:3];
					4'h2: vol_voice_l  <= wr_data[7:3];
					4'h3: vol_voice_r  <= wr_data[7:3];
					4'h4: vol_fm_l     <= wr_data[7:3];
					4'h5: vol_fm_r     <= wr_data[7:3];
					4'h6: vol_cd_l     <= wr_data[7:3];
					4'h7: vol_cd_r     <= wr_data[7:3];
					4'h8: vol_line_l   <= wr_data[7:3];
					4'h9: vol_line_r   <= wr_data[7:3];
					4'hB: vol_spk      <= wr_data[7:6];
					4'hC: out_en       <= wr_data[4:0];
					4'hD: rec_en_l     <= wr_data[6:0];
					4'hE: rec_en_r     <= wr_data[6:0];
					default: ;
				endcase
			end
		end
	end

	// card configuration and mode flag
	always_ff @(posedge clk) begin
		if (!rst_n || mix_reset) begin
			sb_pro     <= 1'b0;
			irq_sel_7  <= 1'b0;
			irq_sel_10 <= 1'b0;
			dma16_en   <= 1'b1;
		end else if (data_wr) begin
			if (idx == MIX_IRQ_CFG) begin
				if (wr_data == SBPRO_ON)
					sb_pro <= 1'b1;
				else if (wr_data == SBPRO_OFF)
					sb_pro <= 1'b0;
				else begin
					irq_sel_10 <= (wr_data[3:2] == 2'b10);
					irq_sel_7  <= (wr_data[3:2] == 2'b01);
				end
			end
			if (idx == MIX_DMA_CFG)
				dma16_en <= wr_data[5];
		end
	end

	assign irq_sel_5 = ~irq_sel_7 & ~irq_sel_10;
	assign pro_mask  = sb_pro ? 8'hEE : 8'hFF;

	// SB16 single registers by low nibble of the index
	always_comb begin
		sb16_val = '0;
		if (sb16_hit) begin
			case (idx[3:0])
				4'h0: sb16_val = {vol_master_l, 3'd0};
				4'h1: sb16_val = {vol_master_r, 3'd0};
				4'h2: sb16_val = {vol_voice_l, 3'd0};
				4'h3: sb16_val = {vol_voice_r, 3'd0};
				4'h4: sb16_val = {vol_fm_l, 3'd0};
				4'h5: sb16_val = {vol_fm_r, 3'd0};
				4'h6: sb16_val = {vol_cd_l, 3'd0};
				4'h7: sb16_val = {vol_cd_r, 3'd0};
				4'h8: sb16_val = {vol_line_l, 3'd0};
				4'h9: sb16_val = {vol_line_r, 3'd0};
				4'hB: sb16_val = {vol_spk, 6'd0};
				4'hC: sb16_val = {3'd0, out_en};
				4'hD: sb16_val = {1'b0, rec_en_l};
				4'hE: sb16_val = {1'b0, rec_en_r};
				default: sb16_val = '0;
			endcase
		end
	end

	always_comb begin
		case (idx)
			MIX_VOICE_PAIR:  rdata = {vol_voice_l[4:1], vol_voice_r[4:1]} & pro_mask;
			MIX_STEREO:      rdata = {6'd0, sbp_stereo, 1'b0};
			MIX_MASTER_PAIR: rdata = {vol_master_l[4:1], vol_master_r[4:1]} & pro_mask;
			MIX_FM_PAIR:     rdata = {vol_fm_l[4:1], vol_fm_r[4:1]} & pro_mask;
			MIX_CD_PAIR:     rdata = {vol_cd_l[4:1], vol_cd_r[4:1]} & pro_mask;
			MIX_LINE_PAIR:   rdata = {vol_line_l[4:1], vol_line_r[4:1]} & pro_mask;
			MIX_IRQ_CFG:     rdata = {4'h0, irq_sel_10, irq_sel_7, irq_sel_5, 1'b0};
			MIX_DMA_CFG:     rdata = {2'b00, dma16_en, 1'b0, 4'h2}; // DMA 5 and 1
			MIX_IRQ_STAT:    rdata = {6'd0, irq16, irq8};
			default:         rdata = sb16_val;
		endcase
		if (sb_pro && (idx >= MIX_SB16_LO))
			rdata = '0;
	end

	// bus stays quiet between reads
	assign mix_rdata = data_rd ? rdata : '0;

endmodule

`default_nettype wire

/* sound_volume_mix.sv */
/* two-stage output mixer, no back-pressure; volumes are sampled in stage one,
   so a level change applies to the next sample entering */
`timescale 1ns/100ps
`default_nettype none

module sound_volume_mix (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                sample_in_valid,
	input  sound_pkg::sample_t dsp_l,
	input  sound_pkg::sample_t dsp_r,
	input  sound_pkg::sample_t fm_l,
	input  sound_pkg::sample_t fm_r,
	input  sound_pkg::vol_t    vol_voice_l,
	input  sound_pkg::vol_t    vol_voice_r,
	input  sound_pkg::vol_t    vol_fm_l,
	input  sound_pkg::vol_t    vol_fm_r,
	output sound_pkg::sample_t sample_l,
	output sound_pkg::sample_t sample_r,
	output logic               sample_out_valid
);

	import sound_pkg::*;

	sample_t dsp_s1_l;
	sample_t dsp_s1_r;
	sample_t fm_s1_l;
	sample_t fm_s1_r;
	logic    s1_valid;

	// 6 dB per step of the upper four volume bits, 0 mutes
	function automatic sample_t scale(input sample_t s, input vol_t v);
		logic [3:0] shamt;
		shamt = 4'd15 - v[4:1];
		if (v == '0)
			return '0;
		return s >>> shamt;
	endfunction

	// stage one, scale
	always_ff @(posedge clk) begin
		if (sample_in_valid) begin
			dsp_s1_l <= scale(dsp_l, vol_voice_l);
			dsp_s1_r <= scale(dsp_r, vol_voice_r);
			fm_s1_l  <= scale(fm_l, vol_fm_l);
			fm_s1_r  <= scale(fm_r, vol_fm_r);
		end
	end

	// stage two, halve both sources so the sum cannot overflow
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			sample_l <= (dsp_s1_l >>> 1) + (fm_s1_l >>> 1);
			sample_r <= (dsp_s1_r >>> 1) + (fm_s1_r >>> 1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid         <= 1'b0;
			sample_out_valid <= 1'b0;
		end else begin
			s1_valid         <= sample_in_valid;
			sample_out_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* sound_top.sv */
/* mixer and host-port slice; DSP, FM and DMA sit outside and feed samples and
   IRQ levels in on clk, strobes are single-cycle without back-pressure */
`timescale 1ns/100ps
`default_nettype none

module sound_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  sound_pkg::io_addr_t   address,
	input  wire                   read,
	input  wire                   write,
	input  sound_pkg::host_data_t writedata,
	input  wire                   sb_cs,
	input  wire                   irq8,
	input  wire                   irq16,
	input  sound_pkg::sample_t    dsp_l,
	input  sound_pkg::sample_t    dsp_r,
	input  sound_pkg::sample_t    fm_l,
	input  sound_pkg::sample_t    fm_r,
	input  wire                   sample_in_valid,
	output sound_pkg::host_data_t readdata,
	output wire                   rd_valid,
	output wire                   irq_5,
	output wire                   irq_7,
	output wire                   irq_10,
	output sound_pkg::sample_t    sample_l,
	output sound_pkg::sample_t    sample_r,
	output wire                   sample_out_valid,
	output sound_pkg::vol_t       vol_l,
	output sound_pkg::vol_t       vol_r,
	output wire [1:0]             vol_spk
);

	import sound_pkg::*;

	wire        idx_wr;
	wire        data_wr;
	wire        data_rd;
	host_data_t wr_data;
	host_data_t mix_rdata;
	wire        irq_sel_7;
	wire        irq_sel_10;
	vol_t       vol_voice_l;
	vol_t       vol_voice_r;
	vol_t       vol_fm_l;
	vol_t       vol_fm_r;

	sound_host_port u_host_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.address    (address),
		.read       (read),
		.write      (write),
		.sb_cs      (sb_cs),
		.writedata  (writedata),
		.mix_rdata  (mix_rdata),
		.irq8       (irq8),
		.irq16      (irq16),
		.irq_sel_7  (irq_sel_7),
		.irq_sel_10 (irq_sel_10),
		.idx_wr     (idx_wr),
		.data_wr    (data_wr),
		.data_rd    (data_rd),
		.wr_data    (wr_data),
		.readdata   (readdata),
		.rd_valid   (rd_valid),
		.irq_5      (irq_5),
		.irq_7      (irq_7),
		.irq_10     (irq_10)
	);

	sound_mixer_regs u_mixer_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.idx_wr       (idx_wr),
		.data_wr      (data_wr),
		.data_rd      (data_rd),
		.wr_data      (wr_data),
		.irq8         (irq8),
		.irq16        (irq16),
		.mix_rdata    (mix_rdata),
		.irq_sel_7    (irq_sel_7),
		.irq_sel_10   (irq_sel_10),
		.sb_pro       (),       // mode flag is for the DSP, outside this slice
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_fm_l     (vol_fm_l),
		.vol_fm_r     (vol_fm_r),
		.vol_master_l (vol_l),  // master goes straight to the codec
		.vol_master_r (vol_r),
		.vol_spk      (vol_spk)
	);

	sound_volume_mix u_volume_mix (
		.clk              (clk),
		.rst_n            (rst_n),
		.sample_in_valid  (sample_in_valid),
		.dsp_l            (dsp_l),
		.dsp_r            (dsp_r),
		.fm_l             (fm_l),
		.fm_r             (fm_r),
		.vol_voice_l      (vol_voice_l),
		.vol_voice_r      (vol_voice_r),
		.vol_fm_l         (vol_fm_l),
		.vol_fm_r         (vol_fm_r),
		.sample_l         (sample_l),
		.sample_r         (sample_r),
		.sample_out_valid (sample_out_valid)
	);

endmodule

`default_nettype wire

/* tb_sound_table.svh */
/* stimulus rows for tb_sound; the levels in the sample rows are the ones that the
   rows before them leave in place, packed as voice l, voice r, fm l, fm r */
`ifndef TB_SOUND_TABLE_SVH
`define TB_SOUND_TABLE_SVH

// columns are operation, index or offset or count, data or expected byte, expected levels
task automatic load_table();
	// reset values
	add_row(OP_GET, 8'h22, 8'hFF, 20'h0);
	add_row(OP_GET, 8'h30, 8'hF8, 20'h0);
	add_row(OP_GET, 8'h3C, 8'h1F, 20'h0);
	add_row(OP_GET, 8'h3D, 8'h15, 20'h0);
	add_row(OP_GET, 8'h80, 8'h02, 20'h0); // IRQ 5
	add_row(OP_GET, 8'h81, 8'h22, 20'h0);
	add_row(OP_VOL, 8'h00, 8'h00, {8'd0, 2'd3, 5'd31, 5'd31});

	// SB16 single registers with the level in bits 7..3
	add_row(OP_SET, 8'h31, 8'h88, 20'h0);
	add_row(OP_SET, 8'h32, 8'h40, 20'h0);
	add_row(OP_SET, 8'h34, 8'h07, 20'h0); // fm left muted
	add_row(OP_SET, 8'h35, 8'h7F, 20'h0);
	add_row(OP_SET, 8'h3B, 8'h95, 20'h0);
	add_row(OP_SET, 8'h3C, 8'hEA, 20'h0);
	add_row(OP_GET, 8'h31, 8'h88, 20'h0);
	add_row(OP_GET, 8'h35, 8'h78, 20'h0);
	add_row(OP_GET, 8'h3B, 8'h80, 20'h0);
	add_row(OP_GET, 8'h3C, 8'h0A, 20'h0);
	add_row(OP_SET, 8'h22, 8'h9C, 20'h0); // master pair 19 / 25
	add_row(OP_GET, 8'h22, 8'h9C, 20'h0);
	add_row(OP_GET, 8'h31, 8'hC8, 20'h0);
	add_row(OP_VOL, 8'h00, 8'h00, {8'd0, 2'd2, 5'd19, 5'd25});

	// sample bursts
	add_row(OP_SMP, 8'd4, 8'h00, {5'd8, 5'd31, 5'd0, 5'd15});
	add_row(OP_SET, 8'h04, 8'h3F, 20'h0); // voice pair 6 / 31
	add_row(OP_SMP, 8'd3, 8'h00, {5'd6, 5'd31, 5'd0, 5'd15});

	// SB Pro mode
	add_row(OP_SET, 8'h80, 8'hAD, 20'h0);
	add_row(OP_GET, 8'h22, 8'h8C, 20'h0);
	add_row(OP_SET, 8'h22, 8'hB7, 20'h0); // widened to 22 / 13
	add_row(OP_GET, 8'h22, 8'hA6, 20'h0);
	add_row(OP_VOL, 8'h00, 8'h00, {8'd0, 2'd2, 5'd22, 5'd13});
	add_row(OP_SET, 8'h30, 8'h20, 20'h0); // ignored
	add_row(OP_GET, 8'h30, 8'h00, 20'h0);
	add_row(OP_SET, 8'h80, 8'hAE, 20'h0);
	add_row(OP_GET, 8'h30, 8'hB0, 20'h0);
	add_row(OP_GET, 8'h22, 8'hB6, 20'h0);

	// IRQ routing with expected lines packed as irq_10, irq_7, irq_5
	add_row(OP_IRQ, 8'h01, 8'h00, 20'h00001);
	add_row(OP_GET, 8'h82, 8'h01, 20'h0);
	add_row(OP_SET, 8'h80, 8'h04, 20'h0); // IRQ 7
	add_row(OP_GET, 8'h80, 8'h04, 20'h0);
	add_row(OP_IRQ, 8'h02, 8'h00, 20'h00002);
	add_row(OP_GET, 8'h82, 8'h02, 20'h0);
	add_row(OP_SET, 8'h80, 8'h08, 20'h0); // IRQ 10
	add_row(OP_IRQ, 8'h03, 8'h00, 20'h00004);
	add_row(OP_GET, 8'h80, 8'h08, 20'h0);
	add_row(OP_SET, 8'h80, 8'h0C, 20'h0); // back to IRQ 5
	add_row(OP_IRQ, 8'h01, 8'h00, 20'h00001);
	add_row(OP_IRQ, 8'h00, 8'h00, 20'h00000);

	// card settings away from their reset values
	add_row(OP_SET, 8'h80, 8'h04, 20'h0); // IRQ 7
	add_row(OP_SET, 8'h81, 8'h00, 20'h0); // 16-bit DMA off
	add_row(OP_GET, 8'h81, 8'h02, 20'h0);
	add_row(OP_SET, 8'h80, 8'hAD, 20'h0);

	// mixer reset at index 0 and then open-bus reads
	add_row(OP_SET, 8'h00, 8'h00, 20'h0);
	add_row(OP_VOL, 8'h00, 8'h00, {8'd0, 2'd3, 5'd31, 5'd31});
	add_row(OP_GET, 8'h22, 8'hFF, 20'h0);
	add_row(OP_GET, 8'h3C, 8'h1F, 20'h0);
	add_row(OP_GET, 8'h80, 8'h02, 20'h0);
	add_row(OP_GET, 8'h81, 8'h22, 20'h0);
	add_row(OP_SMP, 8'd2, 8'h00, {5'd31, 5'd31, 5'd31, 5'd31});
	add_row(OP_RD, 8'h00, 8'hFF, 20'h0);
	add_row(OP_RD, 8'h0A, 8'hFF, 20'h0);
endtask

`endif

/* tb_sound.sv */
/* testbench for the mixer slice; applies the rows of tb_sound_table.svh in order,
   sb_cs stays high after reset and sample bursts use a 16-bit Galois LFSR */
`timescale 1ns/100ps
`default_nettype none

module tb_sound;

	import sound_pkg::*;

	localparam int TIMEOUT = 20; // cycles allowed per wait

	localparam logic [2:0] OP_SET = 3'd0; // index write, then data write
	localparam logic [2:0] OP_GET = 3'd1; // index write, then read at offset 5
	localparam logic [2:0] OP_RD  = 3'd2; // plain read at any offset
	localparam logic [2:0] OP_VOL = 3'd3; // master and speaker levels
	localparam logic [2:0] OP_IRQ = 3'd4; // request levels in, IRQ lines out
	localparam logic [2:0] OP_SMP = 3'd5; // burst of random sample pairs

	typedef struct packed {
		logic [2:0]  op;
		logic [7:0]  arg;  // index, offset, IRQ levels or burst length
		host_data_t  data; // write data or expected byte
		logic [19:0] expv; // packed levels or IRQ lines
	} row_t;

	logic       clk = 1'b0;
	logic       rst_n;
	io_addr_t   address;
	logic       read;
	logic       write;
	host_data_t writedata;
	logic       sb_cs;
	logic       irq8;
	logic       irq16;
	sample_t    dsp_l;
	sample_t    dsp_r;
	sample_t    fm_l;
	sample_t    fm_r;
	logic       sample_in_valid;
	host_data_t readdata;
	logic       rd_valid;
	logic       irq_5;
	logic       irq_7;
	logic       irq_10;
	sample_t    sample_l;
	sample_t    sample_r;
	logic       sample_out_valid;
	vol_t       vol_l;
	vol_t       vol_r;
	logic [1:0] vol_spk;

	row_t        rows[$];
	logic [15:0] lfsr = 16'd54;

	sound_top u_sound_top (.*);

	always #4 clk = ~clk;

	`include "tb_sound_table.svh"

	task automatic add_row(input logic [2:0] op, input logic [7:0] arg,
			input host_data_t data, input logic [19:0] expv);
		rows.push_back({op, arg, data, expv});
	endtask

	task automatic abort_test(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input host_data_t got, input host_data_t want);
		if (got !== want)
			abort_test($sformatf("Mismatch at %0t: %s is %02h, expected %02h",
				$time, name, got, want));
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t want);
		if (got !== want)
			abort_test($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, name, got, want));
	endtask

	task automatic check_vol(input string name, input vol_t got, input vol_t want);
		if (got !== want)
			abort_test($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, name, got, want));
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			abort_test($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, name, got, want));
	endtask

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_sample(output sample_t s);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v    = {v[14:0], lfsr[0]};
		end
		s = v;
	endtask

	// level 0 mutes, else 6 dB per step of the upper four level bits
	function automatic sample_t expect_mix(input sample_t dsp, input sample_t fm,
			input vol_t vv, input vol_t fv);
		int d;
		int f;
		int sum;
		d = 0;
		f = 0;
		if (vv != 5'd0)
			d = int'(dsp) >>> (15 - int'(vv[4:1]));
		if (fv != 5'd0)
			f = int'(fm) >>> (15 - int'(fv[4:1]));
		sum = (d >>> 1) + (f >>> 1);
		return sum[15:0];
	endfunction

	task automatic host_write(input io_addr_t a, input host_data_t d);
		@(posedge clk);
		address   <= a;
		writedata <= d;
		write     <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
	endtask

	task automatic host_read(input io_addr_t a, output host_data_t d);
		int waited;
		waited = 0;
		@(posedge clk);
		address <= a;
		read    <= 1'b1;
		@(posedge clk);
		read <= 1'b0;
		@(negedge clk);
		while (!rd_valid) begin
			waited++;
			if (waited > TIMEOUT)
				abort_test("timed out waiting for rd_valid");
			@(negedge clk);
		end
		if (waited != 0)
			abort_test("rd_valid came later than one cycle after the read strobe");
		d = readdata;
		@(negedge clk);
		check_bit("rd_valid", rd_valid, 1'b0); // single-cycle pulse
	endtask

	// one new pair per cycle, outputs collected while the burst is still going in
	task automatic run_samples(input int count, input logic [19:0] vols);
		sample_t want_l[$];
		sample_t want_r[$];
		int      sent_at[$];
		sample_t dl;
		sample_t dr;
		sample_t fl;
		sample_t fr;
		vol_t    vv_l;
		vol_t    vv_r;
		vol_t    fv_l;
		vol_t    fv_r;
		int      cyc;
		int      sent;
		int      got;
		int      idle;
		{vv_l, vv_r, fv_l, fv_r} = vols;
		cyc  = 0;
		sent = 0;
		got  = 0;
		idle = 0;
		while (got < count) begin
			@(posedge clk);
			cyc++;
			if (sent < count) begin
				take_sample(dl);
				take_sample(dr);
				take_sample(fl);
				take_sample(fr);
				dsp_l           <= dl;
				dsp_r           <= dr;
				fm_l            <= fl;
				fm_r            <= fr;
				sample_in_valid <= 1'b1;
				want_l.push_back(expect_mix(dl, fl, vv_l, fv_l));
				want_r.push_back(expect_mix(dr, fr, vv_r, fv_r));
				sent_at.push_back(cyc);
				sent++;
			end else begin
				sample_in_valid <= 1'b0;
			end
			@(negedge clk);
			if (sample_out_valid) begin
				if (want_l.size() == 0)
					abort_test("sample_out_valid rose with no sample in flight");
				if ((cyc - sent_at.pop_front()) != 2)
					abort_test("sample_out_valid did not follow sample_in_valid by two cycles");
				check_sample("sample_l", sample_l, want_l.pop_front());
				check_sample("sample_r", sample_r, want_r.pop_front());
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT)
					abort_test("timed out waiting for sample_out_valid");
			end
		end
	endtask

	initial begin
		host_data_t got;
		row_t       r;
		rst_n           = 1'b0;
		address         = '0;
		read            = 1'b0;
		write           = 1'b0;
		writedata       = '0;
		sb_cs           = 1'b0;
		irq8            = 1'b0;
		irq16           = 1'b0;
		dsp_l           = '0;
		dsp_r           = '0;
		fm_l            = '0;
		fm_r            = '0;
		sample_in_valid = 1'b0;
		load_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		sb_cs <= 1'b1;
		@(negedge clk);
		check_bit("rd_valid", rd_valid, 1'b0);
		check_bit("sample_out_valid", sample_out_valid, 1'b0);
		foreach (rows[i]) begin
			r = rows[i];
			case (r.op)
				OP_SET: begin
					host_write(IO_MIX_INDEX, r.arg);
					host_write(IO_MIX_DATA, r.data);
				end
				OP_GET: begin
					host_write(IO_MIX_INDEX, r.arg);
					host_read(IO_MIX_DATA, got);
					check_byte($sformatf("readdata at index %02h", r.arg), got, r.data);
				end
				OP_RD: begin
					host_read(r.arg[3:0], got);
					check_byte($sformatf("readdata at offset %0h", r.arg), got, r.data);
				end
				OP_VOL: begin
					@(negedge clk);
					check_vol("vol_l", vol_l, r.expv[9:5]);
					check_vol("vol_r", vol_r, r.expv[4:0]);
					check_vol("vol_spk", {3'd0, vol_spk}, {3'd0, r.expv[11:10]});
				end
				OP_IRQ: begin
					@(posedge clk);
					irq8  <= r.arg[0];
					irq16 <= r.arg[1];
					@(negedge clk);
					check_bit("irq_5", irq_5, r.expv[0]);
					check_bit("irq_7", irq_7, r.expv[1]);
					check_bit("irq_10", irq_10, r.expv[2]);
				end
				OP_SMP: run_samples(int'(r.arg), r.expv);
				default: abort_test("unknown operation in the stimulus table");
			endcase
		end
		@(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
sound_pkg.sv
sound_host_port.sv
sound_mixer_regs.sv
sound_volume_mix.sv
sound_top.sv
tb_sound.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sound -f sources.f -o tb_sound \
	&& ./obj_dir/tb_sound | tee sim.log \
	|| echo "build or simulation did not complete"
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
